// File: mem_region_pkg.sv
package mem_region_pkg;

  // core-side bus widths
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int be_width   = data_width / 8;

  // size of one bank in words and bytes
  localparam int ram_word_addr_width = 10;
  localparam int ram_num_words       = 2 ** ram_word_addr_width;
  localparam int ram_byte_addr_width = ram_word_addr_width + 2;

  // address span checked by the lsu decode
  localparam int region_msb = 31;
  localparam int region_lsb = 20;

  // tag value of the local data region
  localparam logic [region_msb-region_lsb:0] data_region_tag = 12'h001;

  // where the next lsu response comes from
  typedef enum logic [0:0]
  {
    resp_src_ext,
    resp_src_ram
  } resp_src_e;

endpackage

// File: mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if;

  // master side
  logic                                           req;
  logic [mem_region_pkg::ram_byte_addr_width-1:0] addr;
  logic                                           we;
  logic [mem_region_pkg::be_width-1:0]            be;
  logic [mem_region_pkg::data_width-1:0]          wdata;

  // slave side
  logic                                           gnt;
  logic                                           rvalid;
  logic [mem_region_pkg::data_width-1:0]          rdata;

  modport master
  (
    output req,
    output addr,
    output we,
    output be,
    output wdata,
    input  gnt,
    input  rvalid,
    input  rdata
  );

  modport slave
  (
    input  req,
    input  addr,
    input  we,
    input  be,
    input  wdata,
    output gnt,
    output rvalid,
    output rdata
  );

endinterface

// File: sp_ram.sv
`timescale 1ns/1ps

module sp_ram
(
  input  logic                                           clk,
  input  logic                                           en_i,
  input  logic [mem_region_pkg::ram_word_addr_width-1:0] addr_i,
  input  logic                                           we_i,
  input  logic [mem_region_pkg::be_width-1:0]            be_i,
  input  logic [mem_region_pkg::data_width-1:0]          wdata_i,
  output logic [mem_region_pkg::data_width-1:0]          rdata_o
);

  logic [mem_region_pkg::data_width-1:0] mem [mem_region_pkg::ram_num_words];

  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        // only enabled bytes change
        for (int i = 0; i < mem_region_pkg::be_width; i++)
        begin
          if (be_i[i])
          begin
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      else
      begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: ram_mux.sv
`timescale 1ns/1ps

module ram_mux
#(
  parameter bit port1_read_only = 1'b0
)
(
  input  logic                                           clk,
  input  logic                                           rst_n,

  input  logic                                           ld_req_i,
  input  logic [mem_region_pkg::ram_byte_addr_width-1:0] ld_addr_i,
  input  logic                                           ld_we_i,
  input  logic [mem_region_pkg::be_width-1:0]            ld_be_i,
  input  logic [mem_region_pkg::data_width-1:0]          ld_wdata_i,
  output logic [mem_region_pkg::data_width-1:0]          ld_rdata_o,

  mem_port_if.slave                                      core_port,

  output logic                                           ram_en_o,
  output logic [mem_region_pkg::ram_word_addr_width-1:0] ram_addr_o,
  output logic                                           ram_we_o,
  output logic [mem_region_pkg::be_width-1:0]            ram_be_o,
  output logic [mem_region_pkg::data_width-1:0]          ram_wdata_o,
  input  logic [mem_region_pkg::data_width-1:0]          ram_rdata_i
);

  logic                                  core_we;
  logic [mem_region_pkg::be_width-1:0]   core_be;
  logic [mem_region_pkg::data_width-1:0] core_wdata;
  logic                                  ld_owner_q;
  logic                                  core_gnt_q;

  generate
    if (port1_read_only)
    begin : g_read_only
      // fetch side reads full words only
      assign core_we    = 1'b0;
      assign core_be    = '1;
      assign core_wdata = '0;
    end
    else
    begin : g_read_write
      assign core_we    = core_port.we;
      assign core_be    = core_port.be;
      assign core_wdata = core_port.wdata;
    end
  endgenerate

  // loader has fixed priority
  assign core_port.gnt = core_port.req & ~ld_req_i;

  always_comb
  begin
    ram_en_o = ld_req_i | core_port.req;
    if (ld_req_i)
    begin
      ram_addr_o  = ld_addr_i[mem_region_pkg::ram_byte_addr_width-1:2];
      ram_we_o    = ld_we_i;
      ram_be_o    = ld_be_i;
      ram_wdata_o = ld_wdata_i;
    end
    else
    begin
      ram_addr_o  = core_port.addr[mem_region_pkg::ram_byte_addr_width-1:2];
      ram_we_o    = core_we;
      ram_be_o    = core_be;
      ram_wdata_o = core_wdata;
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ld_owner_q <= 1'b0;
      core_gnt_q <= 1'b0;
    end
    else
    begin
      ld_owner_q <= ld_req_i;
      core_gnt_q <= core_port.gnt;
    end
  end

  // response goes to whoever owned the bank last cycle
  assign core_port.rvalid = core_gnt_q;
  assign core_port.rdata  = core_gnt_q ? ram_rdata_i : '0;
  assign ld_rdata_o       = ld_owner_q ? ram_rdata_i : '0;

endmodule

// File: lsu_demux.sv
`timescale 1ns/1ps

module lsu_demux
(
  input  logic                                  clk,
  input  logic                                  rst_n,

  input  logic                                  lsu_req_i,
  input  logic [mem_region_pkg::addr_width-1:0] lsu_addr_i,
  input  logic                                  lsu_we_i,
  input  logic [mem_region_pkg::be_width-1:0]   lsu_be_i,
  input  logic [mem_region_pkg::data_width-1:0] lsu_wdata_i,
  output logic                                  lsu_gnt_o,
  output logic                                  lsu_rvalid_o,
  output logic [mem_region_pkg::data_width-1:0] lsu_rdata_o,

  mem_port_if.master                            ram_port,

  output logic                                  ext_req_o,
  output logic [mem_region_pkg::addr_width-1:0] ext_addr_o,
  output logic                                  ext_we_o,
  output logic [mem_region_pkg::be_width-1:0]   ext_be_o,
  output logic [mem_region_pkg::data_width-1:0] ext_wdata_o,
  input  logic                                  ext_gnt_i,
  input  logic                                  ext_rvalid_i,
  input  logic [mem_region_pkg::data_width-1:0] ext_rdata_i
);

  logic                      is_local;
  mem_region_pkg::resp_src_e resp_src_q;
  mem_region_pkg::resp_src_e resp_src_d;

  assign is_local = (lsu_addr_i[mem_region_pkg::region_msb:mem_region_pkg::region_lsb]
                     == mem_region_pkg::data_region_tag);

  // local data bank
  assign ram_port.req   = lsu_req_i & is_local;
  assign ram_port.addr  = lsu_addr_i[mem_region_pkg::ram_byte_addr_width-1:0];
  assign ram_port.we    = lsu_we_i;
  assign ram_port.be    = lsu_be_i;
  assign ram_port.wdata = lsu_wdata_i;

  // everything else leaves the region
  assign ext_req_o   = lsu_req_i & ~is_local;
  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  assign lsu_gnt_o  = is_local ? ram_port.gnt : (ext_gnt_i & lsu_req_i);
  assign resp_src_d = !lsu_req_i ? resp_src_q :
                      is_local   ? mem_region_pkg::resp_src_ram :
                                   mem_region_pkg::resp_src_ext;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      resp_src_q <= mem_region_pkg::resp_src_ram;
    end
    else
    begin
      resp_src_q <= resp_src_d;
    end
  end

  // route the response back by source
  assign lsu_rvalid_o = (resp_src_q == mem_region_pkg::resp_src_ram) ? ram_port.rvalid
                                                                     : ext_rvalid_i;
  assign lsu_rdata_o  = (resp_src_q == mem_region_pkg::resp_src_ram) ? ram_port.rdata
                                                                     : ext_rdata_i;

endmodule

// File: mem_region_top.sv
`timescale 1ns/1ps

module mem_region_top
(
  input  logic                                           clk,
  input  logic                                           rst_n,

  // core fetch
  input  logic                                           fetch_req_i,
  input  logic [mem_region_pkg::addr_width-1:0]          fetch_addr_i,
  output logic                                           fetch_gnt_o,
  output logic                                           fetch_rvalid_o,
  output logic [mem_region_pkg::data_width-1:0]          fetch_rdata_o,

  // core load/store
  input  logic                                           lsu_req_i,
  input  logic [mem_region_pkg::addr_width-1:0]          lsu_addr_i,
  input  logic                                           lsu_we_i,
  input  logic [mem_region_pkg::be_width-1:0]            lsu_be_i,
  input  logic [mem_region_pkg::data_width-1:0]          lsu_wdata_i,
  output logic                                           lsu_gnt_o,
  output logic                                           lsu_rvalid_o,
  output logic [mem_region_pkg::data_width-1:0]          lsu_rdata_o,

  // external bus
  output logic                                           ext_req_o,
  output logic [mem_region_pkg::addr_width-1:0]          ext_addr_o,
  output logic                                           ext_we_o,
  output logic [mem_region_pkg::be_width-1:0]            ext_be_o,
  output logic [mem_region_pkg::data_width-1:0]          ext_wdata_o,
  input  logic                                           ext_gnt_i,
  input  logic                                           ext_rvalid_i,
  input  logic [mem_region_pkg::data_width-1:0]          ext_rdata_i,

  // instruction bank loader
  input  logic                                           iload_req_i,
  input  logic [mem_region_pkg::ram_byte_addr_width-1:0] iload_addr_i,
  input  logic                                           iload_we_i,
  input  logic [mem_region_pkg::be_width-1:0]            iload_be_i,
  input  logic [mem_region_pkg::data_width-1:0]          iload_wdata_i,
  output logic [mem_region_pkg::data_width-1:0]          iload_rdata_o,

  // data bank loader
  input  logic                                           dload_req_i,
  input  logic [mem_region_pkg::ram_byte_addr_width-1:0] dload_addr_i,
  input  logic                                           dload_we_i,
  input  logic [mem_region_pkg::be_width-1:0]            dload_be_i,
  input  logic [mem_region_pkg::data_width-1:0]          dload_wdata_i,
  output logic [mem_region_pkg::data_width-1:0]          dload_rdata_o
);

  logic                                           instr_en;
  logic [mem_region_pkg::ram_word_addr_width-1:0] instr_addr;
  logic                                           instr_we;
  logic [mem_region_pkg::be_width-1:0]            instr_be;
  logic [mem_region_pkg::data_width-1:0]          instr_wdata;
  logic [mem_region_pkg::data_width-1:0]          instr_rdata;

  logic                                           data_en;
  logic [mem_region_pkg::ram_word_addr_width-1:0] data_addr;
  logic                                           data_we;
  logic [mem_region_pkg::be_width-1:0]            data_be;
  logic [mem_region_pkg::data_width-1:0]          data_wdata;
  logic [mem_region_pkg::data_width-1:0]          data_rdata;

  mem_port_if fetch_port ();
  mem_port_if data_port ();

  // we, be and wdata stay open on the read-only fetch port
  assign fetch_port.req  = fetch_req_i;
  assign fetch_port.addr = fetch_addr_i[mem_region_pkg::ram_byte_addr_width-1:0];
  assign fetch_gnt_o     = fetch_port.gnt;
  assign fetch_rvalid_o  = fetch_port.rvalid;
  assign fetch_rdata_o   = fetch_port.rdata;

  lsu_demux lsu_demux_i
  (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req_i),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_we_i     (lsu_we_i),
    .lsu_be_i     (lsu_be_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .lsu_gnt_o    (lsu_gnt_o),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .ram_port     (data_port),
    .ext_req_o    (ext_req_o),
    .ext_addr_o   (ext_addr_o),
    .ext_we_o     (ext_we_o),
    .ext_be_o     (ext_be_o),
    .ext_wdata_o  (ext_wdata_o),
    .ext_gnt_i    (ext_gnt_i),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i)
  );

  ram_mux #(.port1_read_only(1'b1)) instr_mux
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .ld_req_i    (iload_req_i),
    .ld_addr_i   (iload_addr_i),
    .ld_we_i     (iload_we_i),
    .ld_be_i     (iload_be_i),
    .ld_wdata_i  (iload_wdata_i),
    .ld_rdata_o  (iload_rdata_o),
    .core_port   (fetch_port),
    .ram_en_o    (instr_en),
    .ram_addr_o  (instr_addr),
    .ram_we_o    (instr_we),
    .ram_be_o    (instr_be),
    .ram_wdata_o (instr_wdata),
    .ram_rdata_i (instr_rdata)
  );

  sp_ram instr_ram
  (
    .clk     (clk),
    .en_i    (instr_en),
    .addr_i  (instr_addr),
    .we_i    (instr_we),
    .be_i    (instr_be),
    .wdata_i (instr_wdata),
    .rdata_o (instr_rdata)
  );

  ram_mux #(.port1_read_only(1'b0)) data_mux
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .ld_req_i    (dload_req_i),
    .ld_addr_i   (dload_addr_i),
    .ld_we_i     (dload_we_i),
    .ld_be_i     (dload_be_i),
    .ld_wdata_i  (dload_wdata_i),
    .ld_rdata_o  (dload_rdata_o),
    .core_port   (data_port),
    .ram_en_o    (data_en),
    .ram_addr_o  (data_addr),
    .ram_we_o    (data_we),
    .ram_be_o    (data_be),
    .ram_wdata_o (data_wdata),
    .ram_rdata_i (data_rdata)
  );

  sp_ram data_ram
  (
    .clk     (clk),
    .en_i    (data_en),
    .addr_i  (data_addr),
    .we_i    (data_we),
    .be_i    (data_be),
    .wdata_i (data_wdata),
    .rdata_o (data_rdata)
  );

endmodule

// File: mem_region_props.sv
`timescale 1ns/1ps

module mem_region_props
#(
  parameter bit check_rvalid = 1'b1,
  parameter bit check_route  = 1'b1
)
(
  input logic clk,
  input logic rst_n,
  input logic ext_req_i,
  input logic ram_req_i,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i
);

  int fail_count = 0;

  // a request goes to one side only
  one_target: assert property (@(posedge clk) disable iff (!rst_n || !check_route)
    !(ext_req_i && ram_req_i))
    else
    begin
      fail_count++;
      $error("external and data bank requests high together");
    end

  gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n || !check_route)
    gnt_i |-> req_i)
    else
    begin
      fail_count++;
      $error("grant without request");
    end

  // core response comes one cycle after acceptance and never otherwise
  rvalid_after_accept: assert property (@(posedge clk) disable iff (!rst_n || !check_rvalid)
    (req_i && gnt_i) |=> rvalid_i)
    else
    begin
      fail_count++;
      $error("no rvalid one cycle after an accepted request");
    end

  no_stray_rvalid: assert property (@(posedge clk) disable iff (!rst_n || !check_rvalid)
    !(req_i && gnt_i) |=> !rvalid_i)
    else
    begin
      fail_count++;
      $error("rvalid without an accepted request");
    end

endmodule

bind lsu_demux mem_region_props #(.check_rvalid(1'b0), .check_route(1'b1)) demux_props
(
  .clk       (clk),
  .rst_n     (rst_n),
  .ext_req_i (ext_req_o),
  .ram_req_i (ram_port.req),
  .req_i     (lsu_req_i),
  .gnt_i     (lsu_gnt_o),
  .rvalid_i  (1'b0)
);

bind ram_mux mem_region_props #(.check_rvalid(1'b1), .check_route(1'b0)) mux_props
(
  .clk       (clk),
  .rst_n     (rst_n),
  .ext_req_i (1'b0),
  .ram_req_i (1'b0),
  .req_i     (core_port.req),
  .gnt_i     (core_port.gnt),
  .rvalid_i  (core_port.rvalid)
);

// File: tb_mem_region.sv
`timescale 1ns/1ps

module tb_mem_region;

  localparam int num_words = mem_region_pkg::ram_num_words;
  localparam int num_ld    = 40;
  localparam int num_fetch = 40;
  localparam int num_local = 60;
  localparam int num_ext   = 40;
  localparam int num_mixed = 40;
  localparam int max_wait  = 50;
  // fill counts one op per word and each external op adds a bank readback
  localparam int total_ops = num_words + 4 * num_ld + num_fetch + num_local
                             + 2 * num_ext + num_mixed;

  logic        clk           = 1'b0;
  logic        rst_n         = 1'b0;
  logic        fetch_req_i   = 1'b0;
  logic [31:0] fetch_addr_i  = '0;
  logic        fetch_gnt_o;
  logic        fetch_rvalid_o;
  logic [31:0] fetch_rdata_o;
  logic        lsu_req_i     = 1'b0;
  logic [31:0] lsu_addr_i    = '0;
  logic        lsu_we_i      = 1'b0;
  logic [3:0]  lsu_be_i      = '0;
  logic [31:0] lsu_wdata_i   = '0;
  logic        lsu_gnt_o;
  logic        lsu_rvalid_o;
  logic [31:0] lsu_rdata_o;
  logic        ext_req_o;
  logic [31:0] ext_addr_o;
  logic        ext_we_o;
  logic [3:0]  ext_be_o;
  logic [31:0] ext_wdata_o;
  logic        ext_gnt_i     = 1'b0;
  logic        ext_rvalid_i  = 1'b0;
  logic [31:0] ext_rdata_i   = '0;
  logic        iload_req_i   = 1'b0;
  logic [11:0] iload_addr_i  = '0;
  logic        iload_we_i    = 1'b0;
  logic [3:0]  iload_be_i    = '0;
  logic [31:0] iload_wdata_i = '0;
  logic [31:0] iload_rdata_o;
  logic        dload_req_i   = 1'b0;
  logic [11:0] dload_addr_i  = '0;
  logic        dload_we_i    = 1'b0;
  logic [3:0]  dload_be_i    = '0;
  logic [31:0] dload_wdata_i = '0;
  logic [31:0] dload_rdata_o;

  // bank models and the external request log {we, be, addr, wdata}
  logic [31:0] imem [num_words];
  logic [31:0] dmem [num_words];
  logic [68:0] ext_log [$];
  int          err_count   = 0;
  int          check_count = 0;

  mem_region_top uut (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] fill_word(input logic [9:0] w, input logic [7:0] bank);
    return {bank, 2'b01, w, 2'b10, w};
  endfunction

  function automatic logic [31:0] ext_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
  endfunction

  function automatic logic [31:0] merge_be(input logic [31:0] old_w, input logic [31:0] new_w,
                                           input logic [3:0] be);
    logic [31:0] r;
    r = old_w;
    for (int i = 0; i < 4; i++)
    begin
      if (be[i])
        r[8*i +: 8] = new_w[8*i +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] local_addr();
    return {mem_region_pkg::data_region_tag, 8'($urandom()), 10'($urandom()), 2'b00};
  endfunction

  function automatic logic [31:0] remote_addr();
    logic [31:0] a;
    a = $urandom();
    if (a[31:20] == mem_region_pkg::data_region_tag)
      a[31] = 1'b1;
    return a;
  endfunction

  task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int mark);
    $display("%s: %0d errors", name, err_count - mark);
  endtask

  task automatic ld_access(input bit dbank, input logic [9:0] w, input bit we,
                           input logic [3:0] be, input logic [31:0] wd);
    @(posedge clk);
    if (dbank)
    begin
      dload_req_i   <= 1'b1;
      dload_addr_i  <= {w, 2'b00};
      dload_we_i    <= we;
      dload_be_i    <= be;
      dload_wdata_i <= wd;
    end
    else
    begin
      iload_req_i   <= 1'b1;
      iload_addr_i  <= {w, 2'b00};
      iload_we_i    <= we;
      iload_be_i    <= be;
      iload_wdata_i <= wd;
    end
    @(posedge clk);
    dload_req_i <= 1'b0;
    iload_req_i <= 1'b0;
    if (we && dbank)
      dmem[w] = merge_be(dmem[w], wd, be);
    else if (we)
      imem[w] = merge_be(imem[w], wd, be);
    else
    begin
      @(negedge clk);
      if (dbank)
        check_equal("dload_rdata_o", dload_rdata_o, dmem[w]);
      else
        check_equal("iload_rdata_o", iload_rdata_o, imem[w]);
    end
  endtask

  task automatic fetch_op(input logic [9:0] w, input int stall);
    int n;
    @(posedge clk);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= {20'($urandom()), w, 2'b00};
    if (stall > 0)
    begin
      iload_req_i  <= 1'b1;
      iload_we_i   <= 1'b0;
      iload_addr_i <= 12'($urandom());
      repeat (stall)
      begin
        @(negedge clk);
        check_equal("fetch_gnt_o while loading", 32'(fetch_gnt_o), 32'd0);
        @(posedge clk);
      end
      iload_req_i <= 1'b0;
    end
    n = 0;
    @(negedge clk);
    while (!fetch_gnt_o && n < max_wait)
    begin
      @(negedge clk);
      n++;
    end
    if (!fetch_gnt_o)
    begin
      err_count++;
      $display("fetch of word %h was never granted", w);
    end
    @(posedge clk);
    fetch_req_i <= 1'b0;
    @(negedge clk);
    check_equal("fetch_rvalid_o", 32'(fetch_rvalid_o), 32'd1);
    check_equal("fetch_rdata_o", fetch_rdata_o, imem[w]);
  endtask

  task automatic lsu_op(input logic [31:0] addr, input bit we, input logic [3:0] be,
                        input logic [31:0] wd, input int stall);
    int          n;
    int          log_size;
    bit          is_loc;
    logic [9:0]  w;
    logic [68:0] entry;
    is_loc   = (addr[31:20] == mem_region_pkg::data_region_tag);
    w        = addr[11:2];
    log_size = ext_log.size();
    @(posedge clk);
    lsu_req_i   <= 1'b1;
    lsu_addr_i  <= addr;
    lsu_we_i    <= we;
    lsu_be_i    <= be;
    lsu_wdata_i <= wd;
    if (stall > 0)
    begin
      // data loader takes the bank first
      dload_req_i  <= 1'b1;
      dload_we_i   <= 1'b0;
      dload_addr_i <= 12'($urandom());
      repeat (stall)
      begin
        @(negedge clk);
        check_equal("lsu_gnt_o while loading", 32'(lsu_gnt_o), 32'd0);
        @(posedge clk);
      end
      dload_req_i <= 1'b0;
    end
    n = 0;
    @(negedge clk);
    while (!lsu_gnt_o && n < max_wait)
    begin
      @(negedge clk);
      n++;
    end
    if (!lsu_gnt_o)
    begin
      err_count++;
      $display("lsu request to %h was never granted", addr);
    end
    if (is_loc)
      check_equal("ext_req_o on local access", 32'(ext_req_o), 32'd0);
    @(posedge clk);
    lsu_req_i <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!lsu_rvalid_o && n < max_wait)
    begin
      @(negedge clk);
      n++;
    end
    if (!lsu_rvalid_o)
    begin
      err_count++;
      $display("lsu request to %h got no response", addr);
    end
    if (is_loc)
    begin
      check_equal("local rvalid delay", 32'(n), 32'd0);
      check_equal("ext requests on local access", 32'(ext_log.size()), 32'(log_size));
      if (we)
        dmem[w] = merge_be(dmem[w], wd, be);
      else
        check_equal("lsu_rdata_o local", lsu_rdata_o, dmem[w]);
    end
    else
    begin
      check_equal("ext requests logged", 32'(ext_log.size()), 32'(log_size + 1));
      entry = ext_log[ext_log.size() - 1];
      check_equal("ext_addr_o", entry[63:32], addr);
      check_equal("ext_wdata_o", entry[31:0], wd);
      check_equal("ext_we_o and ext_be_o", 32'(entry[68:64]), 32'({we, be}));
      if (!we)
        check_equal("lsu_rdata_o external", lsu_rdata_o, ext_word(addr));
    end
  endtask

  initial
  begin : main
    int          mark;
    int          prop_fails;
    logic [31:0] a;
    logic [9:0]  w;
    void'($urandom(32'h29919818));
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    mark = err_count;
    @(negedge clk);
    check_equal("fetch_gnt_o", 32'(fetch_gnt_o), 32'd0);
    check_equal("fetch_rvalid_o", 32'(fetch_rvalid_o), 32'd0);
    check_equal("lsu_gnt_o", 32'(lsu_gnt_o), 32'd0);
    check_equal("lsu_rvalid_o", 32'(lsu_rvalid_o), 32'd0);
    check_equal("ext_req_o", 32'(ext_req_o), 32'd0);
    report_test("reset state", mark);

    // fill both banks in parallel with a pattern over the whole word address
    for (int k = 0; k < num_words; k++)
    begin
      @(posedge clk);
      iload_req_i   <= 1'b1;
      iload_we_i    <= 1'b1;
      iload_be_i    <= 4'hf;
      iload_addr_i  <= {k[9:0], 2'b00};
      iload_wdata_i <= fill_word(k[9:0], 8'h1c);
      dload_req_i   <= 1'b1;
      dload_we_i    <= 1'b1;
      dload_be_i    <= 4'hf;
      dload_addr_i  <= {k[9:0], 2'b00};
      dload_wdata_i <= fill_word(k[9:0], 8'hd7);
      imem[k[9:0]] = fill_word(k[9:0], 8'h1c);
      dmem[k[9:0]] = fill_word(k[9:0], 8'hd7);
    end
    @(posedge clk);
    iload_req_i <= 1'b0;
    dload_req_i <= 1'b0;

    mark = err_count;
    for (int i = 0; i < num_ld; i++)
    begin
      for (int b = 0; b < 2; b++)
      begin
        w = 10'($urandom());
        ld_access(b[0], w, 1'b1, 4'($urandom()), $urandom());
        ld_access(b[0], w, 1'b0, 4'h0, 32'h0);
      end
    end
    report_test("loader byte writes and reads", mark);

    mark = err_count;
    for (int i = 0; i < num_fetch; i++)
      fetch_op(10'($urandom()), (i % 4 == 3) ? int'($urandom_range(1, 4)) : 0);
    report_test("fetch with loader priority", mark);

    mark = err_count;
    for (int i = 0; i < num_local; i++)
      lsu_op(local_addr(), 1'($urandom()), 4'($urandom()), $urandom(),
             (i % 5 == 4) ? int'($urandom_range(1, 3)) : 0);
    report_test("local lsu accesses", mark);

    mark = err_count;
    for (int i = 0; i < num_ext; i++)
    begin
      a = remote_addr();
      lsu_op(a, 1'($urandom()), 4'($urandom()), $urandom(), 0);
      ld_access(1'b1, a[11:2], 1'b0, 4'h0, 32'h0);
    end
    report_test("external lsu accesses", mark);

    mark = err_count;
    for (int i = 0; i < num_mixed; i++)
    begin
      a = (i % 2 == 0) ? local_addr() : remote_addr();
      lsu_op(a, 1'($urandom()), 4'($urandom()), $urandom(), 0);
    end
    report_test("alternating local and external", mark);

    // bound assertions count their own failures
    prop_fails = uut.lsu_demux_i.demux_props.fail_count
                 + uut.instr_mux.mux_props.fail_count
                 + uut.data_mux.mux_props.fail_count;
    check_equal("assertion failures", 32'(prop_fails), 32'd0);

    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // external slave with random grant and response delays
  initial
  begin : ext_responder
    int          gnt_dly;
    int          rsp_dly;
    logic [31:0] req_addr;
    forever
    begin
      @(negedge clk);
      if (ext_req_o)
      begin
        ext_log.push_back({ext_we_o, ext_be_o, ext_addr_o, ext_wdata_o});
        req_addr = ext_addr_o;
        gnt_dly  = int'($urandom_range(0, 3));
        rsp_dly  = int'($urandom_range(1, 3));
        repeat (gnt_dly) @(posedge clk);
        @(posedge clk);
        ext_gnt_i <= 1'b1;
        @(posedge clk);
        ext_gnt_i <= 1'b0;
        repeat (rsp_dly - 1) @(posedge clk);
        ext_rvalid_i <= 1'b1;
        ext_rdata_i  <= ext_word(req_addr);
        @(posedge clk);
        ext_rvalid_i <= 1'b0;
      end
    end
  end

  initial
  begin : watchdog
    repeat (total_ops * 20) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", total_ops * 20);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: sources.f
mem_region_pkg.sv
mem_port_if.sv
sp_ram.sv
ram_mux.sv
lsu_demux.sv
mem_region_top.sv
mem_region_props.sv
tb_mem_region.sv

// File: Makefile
TOP := tb_mem_region

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
